/* project.f */
+incdir+verif
logic/conv_pkg.sv
logic/conv_sequencer.sv
logic/line_buffer.sv
logic/weight_bank.sv
logic/window_mac.sv
logic/conv_engine.sv
verif/tb_conv_engine.sv

/* Bender.yml */
package:
  name: conv_engine

sources:
  - logic/conv_pkg.sv
  - logic/conv_sequencer.sv
  - logic/line_buffer.sv
  - logic/weight_bank.sv
  - logic/window_mac.sv
  - logic/conv_engine.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_conv_engine.sv

/* verif/conv_ref_model.svh */
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

typedef enum int {PAT_MAX, PAT_RAMP, PAT_RAND} pattern_t; // Picture generators
typedef enum int {W_ONE, W_NEG4, W_RAND} wset_t;           // Kernel weight sets

typedef struct packed {
    pattern_t pattern;
    wset_t    wset;
    int       gap_pct;  // Chance of an idle cycle before each pixel
    logic     poke;     // Extra conv_start in the middle of the frame
} case_t;

localparam int N_CASES = 5;
localparam case_t CASES [N_CASES] = '{
    '{PAT_MAX,  W_ONE,  0,  1'b0},
    '{PAT_RAMP, W_NEG4, 0,  1'b1},
    '{PAT_RAND, W_RAND, 0,  1'b0},
    '{PAT_RAND, W_RAND, 30, 1'b0},  // Same data as case 2, with gaps
    '{PAT_RAMP, W_NEG4, 30, 1'b1}   // Same data as case 1, with gaps
};

pix_t    rand_pic [PIC_PIXELS];   // Drawn once at the start of the run
weight_t rand_w   [KERNEL_TAPS];
pix_t    picture  [PIC_PIXELS];   // Picture of the current case
weight_t weights  [KERNEL_TAPS];
result_t golden   [PIC_PIXELS];   // Expected result per raster address

// Builds picture and kernel of a case and its zero-padded 5x5 convolution
function automatic void build_case(case_t c);
    int sum;
    int pr;
    int pc;
    for (int i = 0; i < PIC_PIXELS; i++) begin
        picture[i] = (c.pattern == PAT_MAX)  ? pix_t'(3) :
                     (c.pattern == PAT_RAMP) ? pix_t'((i % PIC_SIZE) / 7) : rand_pic[i];
    end
    for (int t = 0; t < KERNEL_TAPS; t++) begin
        weights[t] = (c.wset == W_ONE)  ? weight_t'(1) :
                     (c.wset == W_NEG4) ? weight_t'(-4) : rand_w[t];
    end
    for (int a = 0; a < PIC_PIXELS; a++) begin
        sum = 0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            pr = a / PIC_SIZE + t / KERNEL_SIZE - PAD;  // Picture row under this tap
            pc = a % PIC_SIZE + t % KERNEL_SIZE - PAD;
            if (pr >= 0 && pr < PIC_SIZE && pc >= 0 && pc < PIC_SIZE) begin
                sum += int'(picture[pr * PIC_SIZE + pc]) * int'(weights[t]); // Signed weight
            end
        end
        golden[a] = result_t'(sum);
    end
endfunction

`endif

/* verif/tb_conv_engine.sv */
`timescale 1ns/1ns

module tb_conv_engine import conv_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int N_REQUESTS = PIC_SIZE - PAD;  // 26 row requests per frame
    localparam int GAP_ALLOW  = 40;              // Idle cycles allowed per request

    logic    clk;
    logic    rst_n;
    logic    conv_start;
    pix_t    pic;
    logic    pic_valid;
    weight_t weight_data;
    logic    weight_valid;
    logic    need_pic;
    result_t conv_result;
    logic    conv_result_valid;
    addr_t   conv_result_addr;
    logic    conv_finish;
    int      cycle;                              // Rising edges seen so far

    `include "conv_ref_model.svh"

    conv_engine conv_engine_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_result(string name, result_t got_v, result_t exp_v);
        if (got_v !== exp_v) begin
            stop_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got_v, exp_v));
        end
    endtask

    task automatic check_addr(string name, addr_t got_v, addr_t exp_v);
        if (got_v !== exp_v) begin
            stop_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got_v, exp_v));
        end
    endtask

    task automatic check_count(string name, int got_v, int exp_v);
        if (got_v !== exp_v) begin
            stop_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got_v, exp_v));
        end
    endtask

    // Host side, answers each row request with the rows it asks for
    task automatic serve_requests(case_t c);
        int first;
        int count;
        for (int req = 0; req < N_REQUESTS; req++) begin
            do @(posedge clk); while (!need_pic);
            first = (req == 0) ? 0 : (req + PAD) * PIC_SIZE;     // Row r+2 after the first
            count = (req == 0) ? (PAD + 1) * PIC_SIZE : PIC_SIZE; // 84 then 28 pixels
            if (req == 5 && c.poke) begin
                conv_start <= 1'b1;                // Ignored outside IDLE
                @(posedge clk);
                conv_start <= 1'b0;
            end
            for (int n = 0; n < count; n++) begin
                while ($urandom_range(99) < c.gap_pct) begin
                    pic_valid <= 1'b0;
                    @(posedge clk);
                end
                pic       <= picture[first + n];
                pic_valid <= 1'b1;
                @(posedge clk);
                if (need_pic) begin
                    stop_run("need_pic pulsed before the previous request was served");
                end
            end
            pic_valid <= 1'b0;
        end
    endtask

    // Checks one frame of results up to conv_finish, then a few quiet cycles
    task automatic collect_frame();
        int n_req;
        int n_addr;
        int last;
        n_req  = 0;
        n_addr = 0;
        last   = 0;
        do begin
            @(posedge clk);
            if (need_pic) begin
                n_req++;
            end
            if (conv_result_valid) begin
                check_addr("conv_result_addr", conv_result_addr, addr_t'(n_addr));
                if (n_addr % PIC_SIZE != 0) begin
                    check_count("cycles between results of a row", cycle - last, 1);
                end
                check_result("conv_result", conv_result, golden[n_addr]);
                last = cycle;
                n_addr++;
            end
        end while (!conv_finish);
        check_count("results before conv_finish", n_addr, PIC_PIXELS);
        check_count("cycles from last result to conv_finish", cycle - last, 1);
        check_count("need_pic pulses", n_req, N_REQUESTS);
        repeat (4) begin
            @(posedge clk);
            check_count("conv_finish after the frame", int'(conv_finish), 0);
            check_count("conv_result_valid after the frame", int'(conv_result_valid), 0);
        end
    endtask

    // Watchdog
    initial begin
        #((8 + N_CASES * (PIC_PIXELS + PIC_SIZE * 4 + N_REQUESTS * GAP_ALLOW) * 4) * CLK_PERIOD);
        stop_run("Timeout because the engine stopped making progress");
    end

    initial begin
        void'($urandom(32'heaef5f89));
        clk          = 1'b0;
        rst_n        = 1'b0;
        conv_start   = 1'b0;
        pic          = '0;
        pic_valid    = 1'b0;
        weight_data  = '0;
        weight_valid = 1'b0;
        cycle        = 0;
        for (int i = 0; i < PIC_PIXELS; i++) begin
            rand_pic[i] = pix_t'($urandom_range(3));
        end
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            rand_w[t] = weight_t'($urandom_range(7)); // -4..3 as two's complement
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin                            // Quiet until the first start
            @(posedge clk);
            check_count("need_pic after reset", int'(need_pic), 0);
            check_count("conv_result_valid after reset", int'(conv_result_valid), 0);
            check_count("conv_finish after reset", int'(conv_finish), 0);
        end
        for (int i = 0; i < N_CASES; i++) begin
            build_case(CASES[i]);
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                weight_data  <= weights[t];         // Raster order while idle
                weight_valid <= 1'b1;
                @(posedge clk);
            end
            weight_valid <= 1'b0;
            conv_start   <= 1'b1;
            @(posedge clk);
            conv_start <= 1'b0;
            fork
                serve_requests(CASES[i]);
                collect_frame();
            join
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* logic/conv_engine.sv */
`timescale 1ns/1ns

module conv_engine import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,               // Async, active low
    input  logic    conv_start,          // Start a frame, ignored unless idle
    input  pix_t    pic,
    input  logic    pic_valid,
    input  weight_t weight_data,
    input  logic    weight_valid,        // Loads next weight in raster order
    output logic    need_pic,            // One-cycle request for picture rows
    output result_t conv_result,
    output logic    conv_result_valid,
    output addr_t   conv_result_addr,
    output logic    conv_finish          // Cycle after the last result
);

    logic                 shift_rows;     // Line buffer shift or clear
    logic                 clear;          // Row-0 shift empties the buffer
    logic                 write_en;
    logic [SLOT_BITS-1:0] write_row;
    col_t                 write_col;
    col_t                 window_col;     // Left edge of the current window
    logic                 issue;
    addr_t                issue_addr;
    window_t              window;
    kernel_t              kernel;

    // Control, counters and row requests
    conv_sequencer conv_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .conv_start (conv_start),
        .pic_valid  (pic_valid),
        .need_pic   (need_pic),
        .shift_rows (shift_rows),
        .clear      (clear),
        .write_en   (write_en),
        .write_row  (write_row),
        .write_col  (write_col),
        .window_col (window_col),
        .issue      (issue),
        .issue_addr (issue_addr),
        .conv_finish(conv_finish)
    );

    // Five padded rows
    line_buffer line_buffer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift_rows(shift_rows),
        .clear     (clear),
        .write_en  (write_en),
        .write_row (write_row),
        .write_col (write_col),
        .pic       (pic),
        .window_col(window_col),
        .window    (window)
    );

    weight_bank weight_bank_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_valid(weight_valid),
        .weight_data (weight_data),
        .kernel      (kernel)
    );

    // Two-stage multiply-add
    window_mac window_mac_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .issue_addr  (issue_addr),
        .window      (window),
        .kernel      (kernel),
        .result      (conv_result),
        .result_valid(conv_result_valid),
        .result_addr (conv_result_addr)
    );

endmodule

/* logic/window_mac.sv */
`timescale 1ns/1ns

module window_mac import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue,         // One window per cycle
    input  addr_t   issue_addr,
    input  window_t window,
    input  kernel_t kernel,
    output result_t result,
    output logic    result_valid,  // MAC_LATENCY cycles after issue
    output addr_t   result_addr
);

    prod_t   prod_q [KERNEL_TAPS]; // Stage 1 products
    logic    valid_q;
    addr_t   addr_q;
    result_t sum;                  // Stage 2 input

    // Stage 1, zero-extended pixel times signed weight
    always_ff @(posedge clk) begin
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            prod_q[t] <= $signed({1'b0, window[t]}) * kernel[t];
        end
        addr_q <= issue_addr;
    end

    // Adder tree over the 25 products, sign-extended
    always_comb begin
        sum = '0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            sum = sum + result_t'(prod_q[t]);
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        result      <= sum;
        result_addr <= addr_q;  // Address follows its window
    end

    // Valid bits carry through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            valid_q      <= issue;
            result_valid <= valid_q;
        end
    end

endmodule

/* logic/weight_bank.sv */
`timescale 1ns/1ns

module weight_bank import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    weight_valid,
    input  weight_t weight_data,
    output kernel_t kernel        // Held until reloaded
);

    tap_t wr_ptr; // Next tap to load, raster order

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernel <= '{default: '0};
            wr_ptr <= '0;
        end else if (weight_valid) begin
            kernel[wr_ptr] <= weight_data;
            if (wr_ptr == tap_t'(KERNEL_TAPS - 1)) begin
                wr_ptr <= '0; // Wrap after the 25th weight
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

/* logic/line_buffer.sv */
`timescale 1ns/1ns

module line_buffer import conv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 shift_rows,  // Move rows up, zero the bottom
    input  logic                 clear,       // Zero every row instead of shifting
    input  logic                 write_en,
    input  logic [SLOT_BITS-1:0] write_row,   // Slot 0 is the top row
    input  col_t                 write_col,   // Already offset by the padding
    input  pix_t                 pic,
    input  col_t                 window_col,
    output window_t              window
);

    // Columns 0, 1, 30 and 31 hold the zero border and are never written
    pix_t rows [KERNEL_SIZE][LINE_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows <= '{default: '0};
        end else if (shift_rows) begin
            if (clear) begin
                rows <= '{default: '0}; // Top padding for the first output row
            end else begin
                for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
                    rows[r] <= rows[r + 1];
                end
                rows[KERNEL_SIZE - 1] <= '{default: '0}; // Filled by the next request
            end
        end else if (write_en) begin
            rows[write_row][write_col] <= pic;
        end
    end

    // 5x5 window, left edge at window_col of the padded row
    always_comb begin
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int c = 0; c < KERNEL_SIZE; c++) begin
                window[r * KERNEL_SIZE + c] = rows[r][window_col + c];
            end
        end
    end

endmodule

/* logic/conv_sequencer.sv */
`timescale 1ns/1ns

module conv_sequencer import conv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 conv_start,
    input  logic                 pic_valid,
    output logic                 need_pic,    // One-cycle row request
    output logic                 shift_rows,
    output logic                 clear,       // With shift_rows at output row 0
    output logic                 write_en,
    output logic [SLOT_BITS-1:0] write_row,
    output col_t                 write_col,
    output col_t                 window_col,
    output logic                 issue,
    output addr_t                issue_addr,
    output logic                 conv_finish
);

    seq_state_t           state;
    row_t                 out_row;      // Output row being produced
    logic [SLOT_BITS-1:0] fill_row;     // Row within a request, 0..2 for row 0
    col_t                 fill_col;     // Picture column of next pixel
    col_t                 issue_col;    // Window column being issued
    logic [1:0]           drain_cnt;    // Cycles waited after the last issue
    logic                 shift_pend;   // First FILL cycle, buffer shifts
    logic                 req_pend;     // Second FILL cycle, request goes out
    logic                 draining;     // All 28 windows of the row issued
    logic                 row_needs_pic;
    logic [SLOT_BITS-1:0] fill_last;    // Last row index of this request

    assign row_needs_pic = out_row < row_t'(PIC_SIZE - PAD); // Rows 26, 27 get zeros
    assign fill_last     = (out_row == '0) ? SLOT_BITS'(PAD) : '0;

    // Line buffer steering
    assign need_pic   = req_pend;
    assign shift_rows = shift_pend;
    assign clear      = shift_pend && (out_row == '0);
    assign write_en   = (state == FILL) && !shift_pend && pic_valid;
    assign write_row  = (out_row == '0) ? fill_row + SLOT_BITS'(PAD)
                                        : SLOT_BITS'(KERNEL_SIZE - 1); // New bottom row
    assign write_col  = fill_col + col_t'(PAD);

    // Window issue
    assign window_col = issue_col;
    assign issue      = (state == CALC) && !draining;
    assign issue_addr = addr_t'(out_row) * addr_t'(PIC_SIZE) + addr_t'(issue_col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            out_row     <= '0;
            fill_row    <= '0;
            fill_col    <= '0;
            issue_col   <= '0;
            drain_cnt   <= '0;
            shift_pend  <= 1'b0;
            req_pend    <= 1'b0;
            draining    <= 1'b0;
            conv_finish <= 1'b0;
        end else begin
            conv_finish <= 1'b0; // Single-cycle pulse
            case (state)
                IDLE: begin
                    if (conv_start) begin
                        state      <= FILL;
                        out_row    <= '0;
                        shift_pend <= 1'b1;
                    end
                end
                FILL: begin
                    if (shift_pend) begin
                        shift_pend <= 1'b0;
                        fill_row   <= '0;
                        fill_col   <= '0;
                        if (row_needs_pic) begin
                            req_pend <= 1'b1;
                        end else begin
                            state <= CALC; // Bottom row stays zero
                        end
                    end else begin
                        req_pend <= 1'b0;
                        if (pic_valid) begin
                            if (fill_col == col_t'(PIC_SIZE - 1)) begin
                                fill_col <= '0;
                                if (fill_row == fill_last) begin
                                    state <= CALC; // Request complete
                                end else begin
                                    fill_row <= fill_row + 1'b1;
                                end
                            end else begin
                                fill_col <= fill_col + 1'b1;
                            end
                        end
                    end
                end
                CALC: begin
                    if (!draining) begin
                        if (issue_col == col_t'(PIC_SIZE - 1)) begin
                            issue_col <= '0;
                            draining  <= 1'b1;
                            drain_cnt <= '0;
                        end else begin
                            issue_col <= issue_col + 1'b1;
                        end
                    end else if (drain_cnt == 2'(MAC_LATENCY - 1)) begin
                        // Last result of the row leaves the MAC this cycle
                        draining  <= 1'b0;
                        drain_cnt <= '0;
                        if (out_row == row_t'(PIC_SIZE - 1)) begin
                            state       <= IDLE;
                            conv_finish <= 1'b1;
                        end else begin
                            state      <= FILL;
                            out_row    <= out_row + 1'b1;
                            shift_pend <= 1'b1;
                        end
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/conv_pkg.sv */
package conv_pkg;

    // Picture and kernel geometry
    localparam int PIX_BITS    = 2;                         // Unsigned pixel
    localparam int WEIGHT_BITS = 3;                         // Signed weight
    localparam int KERNEL_SIZE = 5;
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE; // 25 taps
    localparam int PIC_SIZE    = 28;
    localparam int PIC_PIXELS  = PIC_SIZE * PIC_SIZE;       // 784 results per frame
    localparam int PAD         = KERNEL_SIZE / 2;           // Zero border on each side
    localparam int LINE_WIDTH  = PIC_SIZE + 2 * PAD;        // Padded row, 32 pixels

    // Arithmetic widths
    localparam int PROD_BITS   = PIX_BITS + WEIGHT_BITS;    // One product, -12..9
    localparam int RESULT_BITS = 10;                        // Sum of 25 products

    // Derived index widths
    localparam int ADDR_BITS   = $clog2(PIC_PIXELS);        // 10 bits
    localparam int IDX_BITS    = $clog2(PIC_SIZE);          // 5 bits
    localparam int TAP_BITS    = $clog2(KERNEL_TAPS);       // 5 bits
    localparam int SLOT_BITS   = $clog2(KERNEL_SIZE);       // Line buffer row slot

    // Cycles from window issue to result
    localparam int MAC_LATENCY = 2;

    typedef logic        [PIX_BITS-1:0]    pix_t;
    typedef logic signed [WEIGHT_BITS-1:0] weight_t;
    typedef logic signed [PROD_BITS-1:0]   prod_t;
    typedef logic signed [RESULT_BITS-1:0] result_t;
    typedef logic        [ADDR_BITS-1:0]   addr_t;   // row * 28 + col
    typedef logic        [IDX_BITS-1:0]    row_t;
    typedef logic        [IDX_BITS-1:0]    col_t;
    typedef logic        [TAP_BITS-1:0]    tap_t;

    typedef enum logic [1:0] {
        IDLE, // Waiting for start, weights may be loaded
        FILL, // Shifting and loading picture rows
        CALC  // Issuing windows, then draining the MAC
    } seq_state_t;

    // Raster order, tap index is row * KERNEL_SIZE + col
    typedef pix_t    window_t [KERNEL_TAPS];
    typedef weight_t kernel_t [KERNEL_TAPS];

endpackage
